// File: src.f
+incdir+source
source/bsg_chip_pkg.sv
source/bsg_tag_rx.sv
source/bsg_tag_client_regs.sv
source/bsg_link_downstream.sv
source/bsg_chip_core_lane.sv
source/bsg_link_upstream.sv
source/bsg_chip.sv
sim/bsg_clock_gen.sv
sim/bsg_chip_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then judge the result from the log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module bsg_chip_tb \
  -o bsg_chip_tb_sim > build.log 2>&1 \
  && ./obj_dir/bsg_chip_tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; cat build.log; exit 1; }
cat sim.log
grep -qx "STATUS: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: sim/bsg_chip_tb.sv
`timescale 1ns/100ps

module bsg_chip_tb
  import bsg_chip_pkg::*;
  ();

  logic       clk;
  logic       reset;
  logic       tag_en;
  logic       tag_data;
  logic       link_v;
  logic [7:0] link_data;
  logic       link_tkn = 1'b0;
  logic       link_tkn_out;
  logic       link_v_out;
  logic [7:0] link_data_out;

  // Output monitor and far side credit model
  bsg_link_word_t rx_q[$];
  bsg_link_word_t exp_q[$];
  logic [7:0]     low_beat = 8'h00;
  logic           beat_hi = 1'b0;
  int             words_rx = 0;
  int             words_ret = 0;
  int             tkn_out_cnt = 0;
  bit             auto_credit = 1'b1;
  int             manual_req = 0;
  int             manual_done = 0;
  int             cfg_lg = 0;

  logic [31:0]    rng = 32'hd1ab_5773;
  logic [7:0]     core_offset = 8'h00;
  int             value_errs = 0;
  int             timeout_errs = 0;

  bsg_clock_gen #(.period_ns_p(20)) clock_gen (.clk_o(clk));

  bsg_chip DUT
    (.clk_i      ( clk           )
    ,.reset_i    ( reset         )
    ,.tag_en_i   ( tag_en        )
    ,.tag_data_i ( tag_data      )
    ,.link_v_i   ( link_v        )
    ,.link_data_i( link_data     )
    ,.link_tkn_o ( link_tkn_out  )
    ,.link_v_o   ( link_v_out    )
    ,.link_data_o( link_data_out )
    ,.link_tkn_i ( link_tkn      )
    );

  //////////////////////////////////////////////////////////////////////
  // Monitor, then far side token return

  always @(negedge clk)
  begin
    if (link_tkn_out === 1'b1)
      tkn_out_cnt++;
    if (link_v_out === 1'b1)
    begin
      // Low beat first
      if (beat_hi)
      begin
        rx_q.push_back({link_data_out, low_beat});
        words_rx++;
      end
      else
        low_beat = link_data_out;
      beat_hi = ~beat_hi;
    end
    if ((auto_credit || manual_req > manual_done) && (words_rx - words_ret >= (1 << cfg_lg)))
    begin
      link_tkn = 1'b1;
      words_ret += 1 << cfg_lg;
      if (!auto_credit)
        manual_done++;
    end
    else
      link_tkn = 1'b0;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string test, input int expected, input int actual);
    assert (expected == actual)
    else
    begin
      $display("** Error %s: expected %0h, actual %0h", test, expected, actual);
      value_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic send_tag(input bsg_tag_client_e id, input logic [7:0] payload);
    logic [9:0] bits;
    bits = {id, payload};
    @(negedge clk);
    tag_en = 1'b1;
    tag_data = 1'b1;
    for (int i = 9; i >= 0; i--)
    begin
      @(negedge clk);
      tag_data = bits[i];
    end
    @(negedge clk);
    tag_en = 1'b0;
    tag_data = 1'b0;
    // Registers take effect two cycles after the last bit
    repeat (3) @(negedge clk);
  endtask

  task automatic set_link(input logic en, input logic [1:0] lg);
    bsg_link_cfg_s cfg;
    cfg = '0;
    cfg.enable = en;
    cfg.lg_decimation = lg;
    send_tag(TAG_LINK, cfg);
    @(posedge clk);
    cfg_lg = int'(lg);
  endtask

  task automatic send_word(input bsg_link_word_t w);
    @(negedge clk);
    link_v = 1'b1;
    link_data = w[7:0];
    @(negedge clk);
    link_data = w[15:8];
  endtask

  task automatic send_words(input int n);
    bsg_link_word_t w;
    for (int i = 0; i < n; i++)
    begin
      rng = xorshift32(rng);
      w = rng[15:0];
      exp_q.push_back(w + {8'h00, core_offset});
      send_word(w);
    end
    @(negedge clk);
    link_v = 1'b0;
  endtask

  task automatic set_far_side(input bit on);
    @(posedge clk);
    auto_credit = on;
  endtask

  task automatic request_token();
    @(posedge clk);
    manual_req++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Waits and checks

  task automatic wait_words(input string test, input int n, input int limit);
    int cycles;
    cycles = 0;
    while (rx_q.size() < n && cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    assert (rx_q.size() >= n)
    else
    begin
      $display("Timeout in %s: only %0d of %0d words came out", test, rx_q.size(), n);
      timeout_errs++;
    end
  endtask

  task automatic wait_credits_home(input string test);
    int cycles;
    cycles = 0;
    while (words_rx != words_ret && cycles < 100)
    begin
      @(posedge clk);
      cycles++;
    end
    assert (words_rx == words_ret)
    else
    begin
      $display("Timeout in %s: far side still owes %0d credits", test, words_rx - words_ret);
      timeout_errs++;
    end
  endtask

  task automatic expect_quiet(input string test, input int cycles, input int words);
    repeat (cycles) @(posedge clk);
    check_value({test, " words while stalled"}, words, rx_q.size());
  endtask

  task automatic check_words(input string test);
    bsg_link_word_t got;
    repeat (20) @(posedge clk);
    check_value({test, " word count"}, exp_q.size(), rx_q.size());
    while (exp_q.size() > 0 && rx_q.size() > 0)
    begin
      got = rx_q.pop_front();
      check_value(test, int'(exp_q.pop_front()), int'(got));
    end
    rx_q.delete();
    exp_q.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic disabled_start();
    send_words(4);
    expect_quiet("disabled start", 200, 0);
    set_link(1'b1, 2'd0);
    wait_words("disabled start", 4, 500);
    check_words("disabled start");
  endtask

  task automatic offset_add();
    rng = xorshift32(rng);
    core_offset = rng[31:24] | 8'h01;
    send_tag(TAG_CORE, core_offset);
    send_words(6);
    wait_words("offset", 6, 500);
    check_words("offset");
  endtask

  task automatic token_return();
    int tkn_start;
    wait_credits_home("token return");
    set_link(1'b1, 2'd1);
    tkn_start = tkn_out_cnt;
    send_words(8);
    wait_words("token return", 8, 500);
    check_words("token return");
    check_value("token return pulses", 4, tkn_out_cnt - tkn_start);
  endtask

  task automatic credit_stall();
    wait_credits_home("credit stall");
    set_link(1'b1, 2'd2);
    set_far_side(1'b0);
    send_words(12);
    wait_words("credit stall", 8, 500);
    expect_quiet("credit stall", 100, 8);
    // One token worth four words
    request_token();
    wait_words("credit stall", 12, 500);
    check_words("credit stall");
    set_far_side(1'b1);
    wait_credits_home("credit stall");
  endtask

  task automatic gating_and_reset();
    logic [9:0] bits;
    bits = {TAG_CORE, ~core_offset};
    // Full packet with the enable held low
    @(negedge clk);
    tag_data = 1'b1;
    for (int i = 9; i >= 0; i--)
    begin
      @(negedge clk);
      tag_data = bits[i];
    end
    @(negedge clk);
    tag_data = 1'b0;
    repeat (3) @(negedge clk);
    send_words(1);
    wait_words("tag gating", 1, 500);
    check_words("tag gating");

    send_tag(TAG_RESET, 8'h00);
    @(posedge clk);
    cfg_lg = 0;
    core_offset = 8'h00;
    send_words(2);
    expect_quiet("reset client", 200, 0);
    set_link(1'b1, 2'd0);
    wait_words("reset client", 2, 500);
    check_words("reset client");
  endtask

  initial
  begin
    reset = 1'b1;
    tag_en = 1'b0;
    tag_data = 1'b0;
    link_v = 1'b0;
    link_data = 8'h00;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    disabled_start();
    offset_add();
    token_return();
    credit_stall();
    gating_and_reset();

    $display("Errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
    if (value_errs + timeout_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: sim/bsg_clock_gen.sv
`timescale 1ns/100ps

module bsg_clock_gen
  #(parameter int period_ns_p = 20)
  (output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #(period_ns_p / 2) clk_o = ~clk_o;
  end

endmodule

// File: source/bsg_chip.sv
`timescale 1ns/100ps

`include "bsg_chip_defines.svh"

module bsg_chip
  import bsg_chip_pkg::*;
  (input  logic                               clk_i
  ,input  logic                               reset_i

  ,input  logic                               tag_en_i
  ,input  logic                               tag_data_i

  ,input  logic                               link_v_i
  ,input  logic [`BSG_LINK_CHANNEL_WIDTH-1:0] link_data_i
  ,output logic                               link_tkn_o

  ,output logic                               link_v_o
  ,output logic [`BSG_LINK_CHANNEL_WIDTH-1:0] link_data_o
  ,input  logic                               link_tkn_i
  );

  bsg_tag_pkt_s   tag_pkt;
  logic           tag_pkt_v;
  bsg_link_cfg_s  link_cfg;
  bsg_core_cfg_s  core_cfg;

  bsg_link_word_t fifo_word;
  logic           fifo_v, fifo_yumi;
  bsg_link_word_t up_word;
  logic           up_v, up_ready;

  //////////////////////////////////////////////////////////////////////
  // Configuration path

  bsg_tag_rx tag_rx
    (.clk_i      ( clk_i      )
    ,.reset_i    ( reset_i    )
    ,.tag_en_i   ( tag_en_i   )
    ,.tag_data_i ( tag_data_i )
    ,.tag_pkt_o  ( tag_pkt    )
    ,.tag_pkt_v_o( tag_pkt_v  )
    );

  bsg_tag_client_regs tag_regs
    (.clk_i      ( clk_i     )
    ,.reset_i    ( reset_i   )
    ,.tag_pkt_i  ( tag_pkt   )
    ,.tag_pkt_v_i( tag_pkt_v )
    ,.link_cfg_o ( link_cfg  )
    ,.core_cfg_o ( core_cfg  )
    );

  //////////////////////////////////////////////////////////////////////
  // Link in, core lane, link out

  bsg_link_downstream link_down
    (.clk_i      ( clk_i       )
    ,.reset_i    ( reset_i     )
    ,.link_v_i   ( link_v_i    )
    ,.link_data_i( link_data_i )
    ,.link_tkn_o ( link_tkn_o  )
    ,.link_cfg_i ( link_cfg    )
    ,.fifo_word_o( fifo_word   )
    ,.fifo_v_o   ( fifo_v      )
    ,.fifo_yumi_i( fifo_yumi   )
    );

  bsg_chip_core_lane core_lane
    (.clk_i      ( clk_i     )
    ,.reset_i    ( reset_i   )
    ,.fifo_word_i( fifo_word )
    ,.fifo_v_i   ( fifo_v    )
    ,.fifo_yumi_o( fifo_yumi )
    ,.core_cfg_i ( core_cfg  )
    ,.up_word_o  ( up_word   )
    ,.up_v_o     ( up_v      )
    ,.up_ready_i ( up_ready  )
    );

  bsg_link_upstream link_up
    (.clk_i      ( clk_i       )
    ,.reset_i    ( reset_i     )
    ,.up_word_i  ( up_word     )
    ,.up_v_i     ( up_v        )
    ,.up_ready_o ( up_ready    )
    ,.link_cfg_i ( link_cfg    )
    ,.link_v_o   ( link_v_o    )
    ,.link_data_o( link_data_o )
    ,.link_tkn_i ( link_tkn_i  )
    );

endmodule

// File: source/bsg_link_upstream.sv
`timescale 1ns/100ps

`include "bsg_chip_defines.svh"

module bsg_link_upstream
  import bsg_chip_pkg::*;
  (input  logic                               clk_i
  ,input  logic                               reset_i

  ,input  bsg_link_word_t                     up_word_i
  ,input  logic                               up_v_i
  ,output logic                               up_ready_o

  ,input  bsg_link_cfg_s                      link_cfg_i

  ,output logic                               link_v_o
  ,output logic [`BSG_LINK_CHANNEL_WIDTH-1:0] link_data_o
  ,input  logic                               link_tkn_i
  );

  localparam int CH_W   = `BSG_LINK_CHANNEL_WIDTH;
  localparam int CRED_W = $clog2(`BSG_LINK_REMOTE_CREDITS + 1) + 1;

  logic [CRED_W-1:0] credits_r;
  logic [CRED_W-1:0] tkn_inc;

  bsg_link_word_t    word_r;
  logic              send_r;
  logic              hi_r;

  //////////////////////////////////////////////////////////////////////
  // Credit counter

  assign tkn_inc = link_tkn_i ? (CRED_W'(1) << link_cfg_i.lg_decimation) : '0;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      credits_r <= CRED_W'(`BSG_LINK_REMOTE_CREDITS);
    else
      credits_r <= credits_r + tkn_inc - CRED_W'(up_v_i);
  end

  assign up_ready_o = ~send_r & link_cfg_i.enable & (credits_r != '0);

  //////////////////////////////////////////////////////////////////////
  // Two-beat sender

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      send_r <= 1'b0;
      hi_r   <= 1'b0;
    end
    else if (up_v_i)
    begin
      send_r <= 1'b1;
      hi_r   <= 1'b0;
    end
    else if (send_r)
    begin
      send_r <= ~hi_r;
      hi_r   <= ~hi_r;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (up_v_i)
      word_r <= up_word_i;
  end

  assign link_v_o    = send_r;
  assign link_data_o = hi_r ? word_r[2*CH_W-1:CH_W] : word_r[CH_W-1:0];

  // Lane only hands over a word while the sender is idle
  word_while_idle_a: assert property (@(posedge clk_i) disable iff (reset_i)
    up_v_i |-> !send_r);

  credit_bound_a: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_r <= CRED_W'(`BSG_LINK_REMOTE_CREDITS));

endmodule

// File: source/bsg_chip_core_lane.sv
`timescale 1ns/100ps

module bsg_chip_core_lane
  import bsg_chip_pkg::*;
  (input  logic           clk_i
  ,input  logic           reset_i

  ,input  bsg_link_word_t fifo_word_i
  ,input  logic           fifo_v_i
  ,output logic           fifo_yumi_o

  ,input  bsg_core_cfg_s  core_cfg_i

  ,output bsg_link_word_t up_word_o
  ,output logic           up_v_o
  ,input  logic           up_ready_i
  );

  bsg_link_word_t word_r;
  logic           up_v_r;

  // Hold off while our own word is still on its way to the sender
  assign fifo_yumi_o = fifo_v_i & up_ready_i & ~up_v_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      up_v_r <= 1'b0;
    else
      up_v_r <= fifo_yumi_o;
  end

  // Offset is zero extended, sum wraps at 16 bits
  always_ff @(posedge clk_i)
  begin
    if (fifo_yumi_o)
      word_r <= fifo_word_i + bsg_link_word_t'(core_cfg_i.offset);
  end

  assign up_word_o = word_r;
  assign up_v_o    = up_v_r;

endmodule

// File: source/bsg_link_downstream.sv
`timescale 1ns/100ps

`include "bsg_chip_defines.svh"

module bsg_link_downstream
  import bsg_chip_pkg::*;
  (input  logic                               clk_i
  ,input  logic                               reset_i

  ,input  logic                               link_v_i
  ,input  logic [`BSG_LINK_CHANNEL_WIDTH-1:0] link_data_i
  ,output logic                               link_tkn_o

  ,input  bsg_link_cfg_s                      link_cfg_i

  ,output bsg_link_word_t                     fifo_word_o
  ,output logic                               fifo_v_o
  ,input  logic                               fifo_yumi_i
  );

  localparam int DEPTH = `BSG_LINK_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`BSG_LINK_CHANNEL_WIDTH-1:0] low_r;
  logic                               phase_r;
  logic                               word_done;

  bsg_link_word_t   mem_r [DEPTH];
  logic [PTR_W-1:0] wptr_r, rptr_r;
  logic [CNT_W-1:0] count_r;
  logic             full;

  logic [2:0]       pop_cnt_r;
  logic [2:0]       dec_last;
  logic             tkn_r;

  //////////////////////////////////////////////////////////////////////
  // Beat assembly

  assign word_done = link_v_i & phase_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      phase_r <= 1'b0;
    else if (link_v_i)
      phase_r <= ~phase_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (link_v_i && !phase_r)
      low_r <= link_data_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Receive FIFO

  always_ff @(posedge clk_i)
  begin
    if (word_done)
      mem_r[wptr_r] <= {link_data_i, low_r};
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (word_done)
        wptr_r <= (wptr_r == PTR_W'(DEPTH - 1)) ? '0 : wptr_r + 1'b1;
      if (fifo_yumi_i)
        rptr_r <= (rptr_r == PTR_W'(DEPTH - 1)) ? '0 : rptr_r + 1'b1;
      case ({word_done, fifo_yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: ;
      endcase
    end
  end

  assign full        = (count_r == CNT_W'(DEPTH));
  assign fifo_v_o    = (count_r != '0);
  assign fifo_word_o = mem_r[rptr_r];

  //////////////////////////////////////////////////////////////////////
  // Token return, one per 2^lg_decimation pops

  assign dec_last = ~(3'b111 << link_cfg_i.lg_decimation);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pop_cnt_r <= '0;
      tkn_r     <= 1'b0;
    end
    else
    begin
      tkn_r <= fifo_yumi_i && (pop_cnt_r >= dec_last);
      if (fifo_yumi_i)
        pop_cnt_r <= (pop_cnt_r >= dec_last) ? '0 : pop_cnt_r + 1'b1;
    end
  end

  assign link_tkn_o = tkn_r;

  no_pop_empty_a: assert property (@(posedge clk_i) disable iff (reset_i)
    fifo_yumi_i |-> fifo_v_o);

  // Far side overran its credits
  no_overrun_a: assert property (@(posedge clk_i) disable iff (reset_i)
    word_done |-> (!full || fifo_yumi_i));

endmodule

// File: source/bsg_tag_client_regs.sv
`timescale 1ns/100ps

module bsg_tag_client_regs
  import bsg_chip_pkg::*;
  (input  logic          clk_i
  ,input  logic          reset_i

  ,input  bsg_tag_pkt_s  tag_pkt_i
  ,input  logic          tag_pkt_v_i

  ,output bsg_link_cfg_s link_cfg_o
  ,output bsg_core_cfg_s core_cfg_o
  );

  bsg_link_cfg_s link_cfg_r;
  bsg_core_cfg_s core_cfg_r;

  //////////////////////////////////////////////////////////////////////
  // Payload decode by client id

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      link_cfg_r <= '0;
      core_cfg_r <= '0;
    end
    else if (tag_pkt_v_i)
    begin
      case (tag_pkt_i.id)
        TAG_LINK:
          link_cfg_r <= tag_pkt_i.payload.link;
        TAG_CORE:
          core_cfg_r <= tag_pkt_i.payload.core;
        TAG_RESET:
        begin
          link_cfg_r <= '0;
          core_cfg_r <= '0;
        end
        default: ;
      endcase
    end
  end

  assign link_cfg_o = link_cfg_r;
  assign core_cfg_o = core_cfg_r;

  reserved_zero_a: assert property (@(posedge clk_i) disable iff (reset_i)
    link_cfg_o.reserved == '0);

endmodule

// File: source/bsg_tag_rx.sv
`timescale 1ns/100ps

module bsg_tag_rx
  import bsg_chip_pkg::*;
  (input  logic         clk_i
  ,input  logic         reset_i

  ,input  logic         tag_en_i
  ,input  logic         tag_data_i

  ,output bsg_tag_pkt_s tag_pkt_o
  ,output logic         tag_pkt_v_o
  );

  localparam int PKT_W = $bits(bsg_tag_pkt_s);
  localparam int CNT_W = $clog2(PKT_W);

  typedef enum logic
  {
    RX_IDLE,
    RX_SHIFT
  } rx_state_e;

  rx_state_e          state_r;
  logic [CNT_W-1:0]   cnt_r;
  logic [PKT_W-1:0]   shift_r;
  logic               pkt_v_r;
  logic               last_bit;

  assign last_bit = (state_r == RX_SHIFT) && tag_en_i && (cnt_r == CNT_W'(PKT_W - 1));

  //////////////////////////////////////////////////////////////////////
  // Start bit detect and bit count

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= RX_IDLE;
      cnt_r   <= '0;
      pkt_v_r <= 1'b0;
    end
    else
    begin
      pkt_v_r <= last_bit;
      case (state_r)
        RX_IDLE:
        begin
          cnt_r <= '0;
          if (tag_en_i && tag_data_i)
            state_r <= RX_SHIFT;
        end
        RX_SHIFT:
        begin
          // Dropping the enable abandons the packet
          if (!tag_en_i || last_bit)
            state_r <= RX_IDLE;
          cnt_r <= cnt_r + 1'b1;
        end
        default: state_r <= RX_IDLE;
      endcase
    end
  end

  // Id first, then payload, MSB first
  always_ff @(posedge clk_i)
  begin
    if ((state_r == RX_SHIFT) && tag_en_i)
      shift_r <= {shift_r[PKT_W-2:0], tag_data_i};
  end

  assign tag_pkt_o   = bsg_tag_pkt_s'(shift_r);
  assign tag_pkt_v_o = pkt_v_r;

endmodule

// File: source/bsg_chip_pkg.sv
`include "bsg_chip_defines.svh"

package bsg_chip_pkg;

  //////////////////////////////////////////////////////////////////////
  // Core words

  typedef logic [`BSG_LINK_WORD_WIDTH-1:0] bsg_link_word_t;

  //////////////////////////////////////////////////////////////////////
  // Tag clients and payload views

  // Id 3 has no client
  typedef enum logic [`BSG_TAG_ID_WIDTH-1:0]
  {
    TAG_LINK  = 2'd0,
    TAG_CORE  = 2'd1,
    TAG_RESET = 2'd2
  } bsg_tag_client_e;

  typedef struct packed
  {
    logic [4:0] reserved;
    logic [1:0] lg_decimation;
    logic       enable;
  } bsg_link_cfg_s;

  typedef struct packed
  {
    logic [`BSG_TAG_PAYLOAD_WIDTH-1:0] offset;
  } bsg_core_cfg_s;

  // Same payload bits, read according to the client id
  typedef union packed
  {
    bsg_link_cfg_s link;
    bsg_core_cfg_s core;
  } bsg_tag_payload_u;

  typedef struct packed
  {
    bsg_tag_client_e  id;
    bsg_tag_payload_u payload;
  } bsg_tag_pkt_s;

endpackage

// File: source/bsg_chip_defines.svh
`ifndef BSG_CHIP_DEFINES_SVH
`define BSG_CHIP_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Link geometry

// One beat on the pins
`define BSG_LINK_CHANNEL_WIDTH 8

// Two beats per word, low beat first
`define BSG_LINK_WORD_WIDTH 16

`define BSG_LINK_FIFO_DEPTH 8
`define BSG_LINK_REMOTE_CREDITS 8

//////////////////////////////////////////////////////////////////////
// Tag packet geometry

`define BSG_TAG_ID_WIDTH 2
`define BSG_TAG_PAYLOAD_WIDTH 8

`endif
